/* fe_regs_pkg.sv */
`default_nettype none

package fe_regs_pkg;

   // settings bus
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   // front-end register blocks
   localparam int SET_TX_FE_BASE = 224;
   localparam int SET_RX_FE_BASE = 232;

   // tx block offsets
   localparam int TX_OFFSET_I = 0;
   localparam int TX_OFFSET_Q = 1;
   localparam int TX_MAG      = 2;
   localparam int TX_PHASE    = 3;
   localparam int TX_MUX      = 4;

   // rx block offsets
   localparam int RX_MAG      = 0;
   localparam int RX_PHASE    = 1;
   localparam int RX_OFFSET_I = 2;
   localparam int RX_OFFSET_Q = 3;
   localparam int RX_IQ_MAP   = 4;
   localparam int RX_HET      = 5;

   localparam int MAP_SWAP_BIT = 0;   // rx iq map register
   localparam int MAP_INVQ_BIT = 1;
   localparam int MUX_SWAP_BIT = 0;   // tx mux register

endpackage

`default_nettype wire

/* fe_settings_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module fe_settings_regs (
   input  wire                                radio_clk,
   input  wire                                i_rst,
   input  wire                                i_set_stb,
   input  wire  [fe_regs_pkg::SET_ADDR_W-1:0] i_set_addr,
   input  wire  [fe_regs_pkg::SET_DATA_W-1:0] i_set_data,
   output radio_sample_pkg::sample_t          o_rx_offset_i,
   output radio_sample_pkg::sample_t          o_rx_offset_q,
   output radio_sample_pkg::sample_t          o_tx_offset_i,
   output radio_sample_pkg::sample_t          o_tx_offset_q,
   output logic                               o_rx_swap_iq,
   output logic                               o_rx_invert_q,
   output logic                               o_tx_swap_iq
);

   import fe_regs_pkg::*;
   import radio_sample_pkg::*;

   sample_t set_offset;   // signed low half of the data word

   assign set_offset = sample_t'(i_set_data[SAMPLE_W-1:0]);

   ////////////////////////////////////////////////////////////////////////////
   // register decode
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_rx_offset_i <= '0;
         o_rx_offset_q <= '0;
         o_tx_offset_i <= '0;
         o_tx_offset_q <= '0;
         o_rx_swap_iq  <= 1'b0;
         o_rx_invert_q <= 1'b0;
         o_tx_swap_iq  <= 1'b0;   // pass-through after reset
      end else if (i_set_stb) begin
         case (i_set_addr)
            // tx block
            SET_TX_FE_BASE + TX_OFFSET_I : o_tx_offset_i <= set_offset;
            SET_TX_FE_BASE + TX_OFFSET_Q : o_tx_offset_q <= set_offset;
            SET_TX_FE_BASE + TX_MUX      : o_tx_swap_iq  <= i_set_data[MUX_SWAP_BIT];

            // rx block
            SET_RX_FE_BASE + RX_OFFSET_I : o_rx_offset_i <= set_offset;
            SET_RX_FE_BASE + RX_OFFSET_Q : o_rx_offset_q <= set_offset;
            SET_RX_FE_BASE + RX_IQ_MAP   : begin
               o_rx_swap_iq  <= i_set_data[MAP_SWAP_BIT];
               o_rx_invert_q <= i_set_data[MAP_INVQ_BIT];
            end

            // mag/phase correction and het dsp are not built
            SET_TX_FE_BASE + TX_MAG,
            SET_TX_FE_BASE + TX_PHASE,
            SET_RX_FE_BASE + RX_MAG,
            SET_RX_FE_BASE + RX_PHASE,
            SET_RX_FE_BASE + RX_HET      : ;

            default : ;   // not ours
         endcase
      end
   end

endmodule

`default_nettype wire

/* radio_frontend.f */
radio_sample_pkg.sv
fe_regs_pkg.sv
fe_settings_regs.sv
rx_frontend.sv
tx_frontend.sv
radio_frontend_top.sv
radio_frontend_tb.sv

/* radio_frontend_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module radio_frontend_tb;

   import radio_sample_pkg::*;
   import fe_regs_pkg::*;

   localparam int CLK_PERIOD = 100;
   localparam int DRIVE_DLY  = 10;     // after the rising edge
   localparam int RX_LAT     = 3;
   localparam int TX_LAT     = 2;
   localparam int MAX_CYCLES = 2000;   // tests need roughly 420 cycles

   logic                  radio_clk;
   logic                  i_rst;
   logic                  i_set_stb;
   logic [SET_ADDR_W-1:0] i_set_addr;
   logic [SET_DATA_W-1:0] i_set_data;
   iq_word_t              i_rx;
   iq_word_t              i_tx;
   logic                  i_tx_stb;
   iq_word_t              o_rx;
   logic                  o_rx_stb;
   iq_word_t              o_tx;
   logic                  o_tx_stb;

   integer seed;
   int     cycles = 0;
   int     checks;
   int     errors;
   int     tests;

   // reference model of the control registers
   sample_t  m_rx_ofs_i;
   sample_t  m_rx_ofs_q;
   logic     m_rx_swap;
   logic     m_rx_invq;
   sample_t  m_tx_ofs_i;
   sample_t  m_tx_ofs_q;
   logic     m_tx_swap;
   iq_word_t m_dac_hold;   // last word on the dac

   radio_frontend_top i_radio_frontend_top (
      .radio_clk  (radio_clk),
      .i_rst      (i_rst),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .i_rx       (i_rx),
      .i_tx       (i_tx),
      .i_tx_stb   (i_tx_stb),
      .o_rx       (o_rx),
      .o_rx_stb   (o_rx_stb),
      .o_tx       (o_tx),
      .o_tx_stb   (o_tx_stb)
   );

   always #(CLK_PERIOD/2) radio_clk = ~radio_clk;

   always @(posedge radio_clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("Testbench failed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////////////////////

   function automatic sample_t clamp16(input int v);
      if (v > 32767) begin
         return 16'sh7fff;
      end
      if (v < -32768) begin
         return 16'sh8000;
      end
      return v[15:0];
   endfunction

   function automatic sample_t add_sat(input sample_t a, input sample_t b);
      return clamp16(int'(a) + int'(b));
   endfunction

   function automatic iq_word_t rx_expect(input iq_word_t s);
      iq_word_t r;
      sample_t  i;
      sample_t  q;
      i = add_sat(s.iq.i, m_rx_ofs_i);
      q = add_sat(s.iq.q, m_rx_ofs_q);
      r.iq.i = m_rx_swap ? q : i;
      r.iq.q = m_rx_swap ? i : q;
      if (m_rx_invq) begin
         r.iq.q = clamp16(-int'(r.iq.q));   // -32768 goes to +32767
      end
      return r;
   endfunction

   function automatic iq_word_t tx_expect(input iq_word_t s);
      iq_word_t r;
      sample_t  i;
      sample_t  q;
      i = add_sat(s.iq.i, m_tx_ofs_i);
      q = add_sat(s.iq.q, m_tx_ofs_q);
      r.iq.i = m_tx_swap ? q : i;
      r.iq.q = m_tx_swap ? i : q;
      return r;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // drivers and checks
   ////////////////////////////////////////////////////////////////////////////

   task automatic next_cycle();
      @(posedge radio_clk);
      #DRIVE_DLY;
   endtask

   task automatic check_val(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("[ERROR] t=%0d ns: %s is %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   // one bus write, then let it settle
   task automatic write_reg(input int addr, input logic [31:0] data);
      i_set_stb  = 1'b1;
      i_set_addr = addr[SET_ADDR_W-1:0];
      i_set_data = data;
      next_cycle();
      i_set_stb = 1'b0;
      repeat (4) next_cycle();
   endtask

   task automatic run_rx(input int n, input bit near_rail);
      iq_word_t exp_q[$];
      iq_word_t s;
      iq_word_t e;
      int       k;
      for (k = 0; k < n + RX_LAT; k++) begin
         if (k >= RX_LAT) begin
            e = exp_q.pop_front();
            check_val("o_rx_stb", {31'd0, o_rx_stb}, 32'd1);
            check_val("o_rx", o_rx.raw, e.raw);
         end
         if (k < n) begin
            s.raw = $random(seed);
            if (near_rail && (k % 4) == 1) begin
               s.iq.i = 16'sh7ff8;
               s.iq.q = 16'sh8008;
            end else if (near_rail && (k % 4) == 2) begin
               s.iq.i = 16'sh8000;
               s.iq.q = 16'sh7fff;
            end else if (near_rail && (k % 4) == 3) begin
               s.iq.q = 16'sh8000;
            end
            i_rx = s;
            exp_q.push_back(rx_expect(s));
         end
         next_cycle();
      end
   endtask

   // gaps drops about one strobe in four
   task automatic run_tx(input int n, input bit gaps);
      logic     stb_q[$];
      iq_word_t word_q[$];
      iq_word_t s;
      iq_word_t e;
      logic     exp_stb;
      int       k;
      for (k = 0; k < n + TX_LAT; k++) begin
         if (k >= TX_LAT) begin
            exp_stb = stb_q.pop_front();
            e = word_q.pop_front();
            if (exp_stb) begin
               m_dac_hold = e;
            end
            check_val("o_tx_stb", {31'd0, o_tx_stb}, {31'd0, exp_stb});
            check_val("o_tx", o_tx.raw, m_dac_hold.raw);   // also checks the hold
         end
         if (k < n) begin
            s.raw    = $random(seed);
            i_tx     = s;
            i_tx_stb = gaps ? (($random(seed) & 3) != 0) : 1'b1;
            stb_q.push_back(i_tx_stb);
            word_q.push_back(tx_expect(s));
         end else begin
            i_tx_stb = 1'b0;
         end
         next_cycle();
      end
   endtask

   task automatic end_test(input string name, input int errs_before);
      tests++;
      if (errors == errs_before) begin
         $display("test %0d %s: ok", tests, name);
      end else begin
         $display("test %0d %s: %0d errors", tests, name, errors - errs_before);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic test_reset_passthrough();
      int e0;
      int w;
      e0 = errors;
      i_rst = 1'b1;
      repeat (5) next_cycle();
      check_val("o_rx_stb in reset", {31'd0, o_rx_stb}, 32'd0);
      check_val("o_tx_stb in reset", {31'd0, o_tx_stb}, 32'd0);
      check_val("o_rx in reset", o_rx.raw, 32'd0);
      check_val("o_tx in reset", o_tx.raw, 32'd0);
      i_rst = 1'b0;
      w = 0;
      while (!o_rx_stb && w < RX_LAT) begin
         next_cycle();
         w++;
      end
      assert (o_rx_stb) else begin
         $display("o_rx_stb did not rise within %0d cycles of reset release", RX_LAT);
         errors++;
      end
      run_rx(50, 1'b0);
      run_tx(50, 1'b0);
      end_test("reset and pass-through", e0);
   endtask

   task automatic test_rx_offset();
      logic [31:0] d;
      int          e0;
      int          rnd;
      e0 = errors;
      for (rnd = 0; rnd < 2; rnd++) begin
         // positive offsets, then negative ones, so both rails clamp
         d = $random(seed) | 32'd1;
         d[15] = (rnd == 1);
         write_reg(SET_RX_FE_BASE + RX_OFFSET_I, d);
         m_rx_ofs_i = d[15:0];
         d = $random(seed) | 32'd1;
         d[15] = (rnd == 1);
         write_reg(SET_RX_FE_BASE + RX_OFFSET_Q, d);
         m_rx_ofs_q = d[15:0];
         run_rx(25, 1'b1);
      end
      end_test("rx dc offset", e0);
   endtask

   task automatic test_rx_mapping();
      logic [31:0] d;
      int          e0;
      int          map;
      e0 = errors;
      write_reg(SET_RX_FE_BASE + RX_OFFSET_I, 32'd0);
      write_reg(SET_RX_FE_BASE + RX_OFFSET_Q, 32'd0);
      m_rx_ofs_i = '0;
      m_rx_ofs_q = '0;
      for (map = 1; map <= 3; map++) begin   // swap, invert, both
         d = '0;
         d[MAP_SWAP_BIT] = map[0];
         d[MAP_INVQ_BIT] = map[1];
         write_reg(SET_RX_FE_BASE + RX_IQ_MAP, d);
         m_rx_swap = map[0];
         m_rx_invq = map[1];
         run_rx(16, 1'b1);
      end
      end_test("rx iq mapping", e0);
   endtask

   task automatic test_tx_path();
      logic [31:0] d;
      int          e0;
      e0 = errors;
      d = $random(seed);
      write_reg(SET_TX_FE_BASE + TX_OFFSET_I, d);
      m_tx_ofs_i = d[15:0];
      d = $random(seed);
      write_reg(SET_TX_FE_BASE + TX_OFFSET_Q, d);
      m_tx_ofs_q = d[15:0];
      write_reg(SET_TX_FE_BASE + TX_MUX, 32'd1 << MUX_SWAP_BIT);
      m_tx_swap = 1'b1;
      // no strobe since the last burst, so the new settings must not reach the dac
      check_val("o_tx between strobes", o_tx.raw, m_dac_hold.raw);
      check_val("o_tx_stb between strobes", {31'd0, o_tx_stb}, 32'd0);
      run_tx(50, 1'b1);
      end_test("tx offset and mux", e0);
   endtask

   task automatic test_ignored_writes();
      int addrs[6];
      int e0;
      int j;
      e0 = errors;
      addrs = '{SET_TX_FE_BASE + TX_MAG, SET_TX_FE_BASE + TX_PHASE,
                SET_RX_FE_BASE + RX_MAG, SET_RX_FE_BASE + RX_PHASE,
                SET_RX_FE_BASE + RX_HET, 16};   // last one is unused
      for (j = 0; j < 6; j++) begin
         write_reg(addrs[j], $random(seed));
      end
      run_rx(20, 1'b1);
      run_tx(20, 1'b1);
      end_test("ignored addresses", e0);
   endtask

   initial begin
      seed       = 32'hb68f;
      radio_clk  = 1'b0;
      i_rst      = 1'b1;
      i_set_stb  = 1'b0;
      i_set_addr = '0;
      i_set_data = '0;
      i_rx       = '0;
      i_tx       = '0;
      i_tx_stb   = 1'b0;
      checks     = 0;
      errors     = 0;
      tests      = 0;
      // model starts at the register reset values
      m_rx_ofs_i = '0;
      m_rx_ofs_q = '0;
      m_rx_swap  = 1'b0;
      m_rx_invq  = 1'b0;
      m_tx_ofs_i = '0;
      m_tx_ofs_q = '0;
      m_tx_swap  = 1'b0;
      m_dac_hold = '0;

      test_reset_passthrough();
      test_rx_offset();
      test_rx_mapping();
      test_tx_path();
      test_ignored_writes();

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* radio_frontend_top.sv */
`timescale 1ns/1ps
`default_nettype none

module radio_frontend_top (
   input  wire                                radio_clk,
   input  wire                                i_rst,
   input  wire                                i_set_stb,
   input  wire  [fe_regs_pkg::SET_ADDR_W-1:0] i_set_addr,
   input  wire  [fe_regs_pkg::SET_DATA_W-1:0] i_set_data,
   input  wire radio_sample_pkg::iq_word_t    i_rx,
   input  wire radio_sample_pkg::iq_word_t    i_tx,
   input  wire                                i_tx_stb,
   output wire radio_sample_pkg::iq_word_t    o_rx,
   output wire                                o_rx_stb,
   output wire radio_sample_pkg::iq_word_t    o_tx,
   output wire                                o_tx_stb
);

   import radio_sample_pkg::*;

   // control from the register block
   wire sample_t rx_offset_i;
   wire sample_t rx_offset_q;
   wire sample_t tx_offset_i;
   wire sample_t tx_offset_q;
   wire          rx_swap_iq;
   wire          rx_invert_q;
   wire          tx_swap_iq;

   fe_settings_regs i_fe_settings_regs (
      .radio_clk     (radio_clk),
      .i_rst         (i_rst),
      .i_set_stb     (i_set_stb),
      .i_set_addr    (i_set_addr),
      .i_set_data    (i_set_data),
      .o_rx_offset_i (rx_offset_i),
      .o_rx_offset_q (rx_offset_q),
      .o_tx_offset_i (tx_offset_i),
      .o_tx_offset_q (tx_offset_q),
      .o_rx_swap_iq  (rx_swap_iq),
      .o_rx_invert_q (rx_invert_q),
      .o_tx_swap_iq  (tx_swap_iq)
   );

   rx_frontend i_rx_frontend (
      .radio_clk  (radio_clk),
      .i_rst      (i_rst),
      .i_adc      (i_rx),
      .i_offset_i (rx_offset_i),
      .i_offset_q (rx_offset_q),
      .i_swap_iq  (rx_swap_iq),
      .i_invert_q (rx_invert_q),
      .o_rx       (o_rx),
      .o_rx_stb   (o_rx_stb)
   );

   tx_frontend i_tx_frontend (
      .radio_clk  (radio_clk),
      .i_rst      (i_rst),
      .i_tx       (i_tx),
      .i_tx_stb   (i_tx_stb),
      .i_offset_i (tx_offset_i),
      .i_offset_q (tx_offset_q),
      .i_swap_iq  (tx_swap_iq),
      .o_dac      (o_tx),
      .o_dac_stb  (o_tx_stb)
   );

endmodule

`default_nettype wire

/* radio_sample_pkg.sv */
`default_nettype none

package radio_sample_pkg;

   localparam int SAMPLE_W = 16;   // one I or Q component

   typedef logic signed [SAMPLE_W-1:0] sample_t;

   // radio bus word, i in the upper half and q in the lower half
   typedef union packed {
      logic [2*SAMPLE_W-1:0] raw;
      struct packed {
         sample_t i;
         sample_t q;
      } iq;
   } iq_word_t;

   // signed add, clamped to the component range
   function automatic sample_t sat_add(input sample_t a, input sample_t b);
      logic signed [SAMPLE_W:0] sum;
      sum = {a[SAMPLE_W-1], a} + {b[SAMPLE_W-1], b};
      if (sum[SAMPLE_W] == sum[SAMPLE_W-1]) begin
         return sum[SAMPLE_W-1:0];   // no overflow
      end
      // sign of the 17 bit sum picks the rail
      return sum[SAMPLE_W] ? {1'b1, {(SAMPLE_W-1){1'b0}}} : {1'b0, {(SAMPLE_W-1){1'b1}}};
   endfunction

endpackage

`default_nettype wire

/* rx_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_frontend (
   input  wire                                 radio_clk,
   input  wire                                 i_rst,
   input  wire radio_sample_pkg::iq_word_t     i_adc,
   input  wire radio_sample_pkg::sample_t      i_offset_i,
   input  wire radio_sample_pkg::sample_t      i_offset_q,
   input  wire                                 i_swap_iq,
   input  wire                                 i_invert_q,
   output radio_sample_pkg::iq_word_t          o_rx,
   output logic                                o_rx_stb
);

   import radio_sample_pkg::*;

   iq_word_t   adc_r;       // capture stage
   iq_word_t   ofs_r;       // dc offset stage
   logic [2:0] vld_sr;      // one bit per stage
   sample_t    map_i;
   sample_t    map_q;
   sample_t    map_q_neg;

   ////////////////////////////////////////////////////////////////////////////
   // capture and dc offset
   ////////////////////////////////////////////////////////////////////////////

   // adc runs every cycle, no strobe needed
   always_ff @(posedge radio_clk) begin
      adc_r.raw  <= i_adc.raw;
      ofs_r.iq.i <= sat_add(adc_r.iq.i, i_offset_i);
      ofs_r.iq.q <= sat_add(adc_r.iq.q, i_offset_q);
   end

   ////////////////////////////////////////////////////////////////////////////
   // iq mapping, output register
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      map_i = i_swap_iq ? ofs_r.iq.q : ofs_r.iq.i;
      map_q = i_swap_iq ? ofs_r.iq.i : ofs_r.iq.q;
      // ~q + 1 with clamp, so -32768 turns into 32767
      map_q_neg = sat_add(~map_q, sample_t'(1));
   end

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_rx.raw <= '0;
         vld_sr   <= '0;
      end else begin
         o_rx.iq.i <= map_i;
         o_rx.iq.q <= i_invert_q ? map_q_neg : map_q;
         vld_sr    <= {vld_sr[1:0], 1'b1};   // fills 3 cycles after reset
      end
   end

   assign o_rx_stb = vld_sr[2];

endmodule

`default_nettype wire

/* tx_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_frontend (
   input  wire                                 radio_clk,
   input  wire                                 i_rst,
   input  wire radio_sample_pkg::iq_word_t     i_tx,
   input  wire                                 i_tx_stb,
   input  wire radio_sample_pkg::sample_t      i_offset_i,
   input  wire radio_sample_pkg::sample_t      i_offset_q,
   input  wire                                 i_swap_iq,
   output radio_sample_pkg::iq_word_t          o_dac,
   output logic                                o_dac_stb
);

   import radio_sample_pkg::*;

   iq_word_t tx_r;       // captured sample
   logic     tx_stb_r;
   sample_t  ofs_i;
   sample_t  ofs_q;

   ////////////////////////////////////////////////////////////////////////////
   // capture
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge radio_clk) begin
      if (i_tx_stb) begin
         tx_r.raw <= i_tx.raw;
      end
   end

   // offsets computed from the captured word
   always_comb begin
      ofs_i = sat_add(tx_r.iq.i, i_offset_i);
      ofs_q = sat_add(tx_r.iq.q, i_offset_q);
   end

   ////////////////////////////////////////////////////////////////////////////
   // offset, mux and dac register
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         tx_stb_r  <= 1'b0;
         o_dac_stb <= 1'b0;
         o_dac.raw <= '0;
      end else begin
         tx_stb_r  <= i_tx_stb;
         o_dac_stb <= tx_stb_r;   // strobe follows the data
         if (tx_stb_r) begin      // dac holds between strobes
            o_dac.iq.i <= i_swap_iq ? ofs_q : ofs_i;
            o_dac.iq.q <= i_swap_iq ? ofs_i : ofs_q;
         end
      end
   end

endmodule

`default_nettype wire
